// ==== hw/soc_pkg.sv ====
// ************************************************************************
// shared definitions of the SoC memory slice
// address map, bus widths, memory sizes and crossbar target encoding
// ************************************************************************

package soc_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // ************************************************************************
  // L2 memory, word interleaved over the banks
  // ************************************************************************
  localparam int    NB_L2_BANKS   = 4;
  localparam int    L2_BANK_WORDS = 64;
  localparam int    L2_BANK_AW    = 6;
  localparam int    L2_BANK_SEL_W = $clog2(NB_L2_BANKS);
  // bank select sits right above the byte offset, row index above that
  localparam int    L2_ROW_LSB    = 2 + L2_BANK_SEL_W;
  localparam addr_t L2_BASE       = 32'h1C00_0000;
  localparam addr_t L2_SPAN       = 32'h0000_0400;

  // boot rom
  localparam int    ROM_WORDS = 16;
  localparam int    ROM_AW    = $clog2(ROM_WORDS);
  localparam addr_t ROM_BASE  = 32'h1A00_0000;
  localparam addr_t ROM_SPAN  = 32'h0000_0040;
  localparam string ROM_FILE  = "hw/boot_rom.hex";

  // prefetch event counter, one word
  localparam addr_t EVT_BASE  = 32'h1A10_0000;
  localparam int    EVT_CNT_W = 8;

  // crossbar targets
  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_L2,
    TGT_EVT,
    TGT_NONE
  } tgt_e;

endpackage

// ==== hw/l2_ram_multi_bank.sv ====
// ************************************************************************
// word-interleaved L2 bank array
// byte-enable writes, one cycle read latency
// ************************************************************************

`timescale 1ns/1ns

module l2_ram_multi_bank import soc_pkg::*; (
  input  logic  s_soc_clk,
  input  logic  s_soc_rstn,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t be_i,
  output data_t rdata_o
);

  logic [L2_BANK_SEL_W-1:0] bank_idx;
  logic [L2_BANK_SEL_W-1:0] bank_sel_q;
  logic [L2_BANK_AW-1:0]    row_idx;
  data_t                    bank_rdata [NB_L2_BANKS];

  // consecutive words land in consecutive banks
  assign bank_idx = addr_i[2 +: L2_BANK_SEL_W];
  assign row_idx  = addr_i[L2_ROW_LSB +: L2_BANK_AW];

  for (genvar b = 0; b < NB_L2_BANKS; b++) begin : gen_bank
    data_t mem [L2_BANK_WORDS];
    data_t rdata_q;
    logic  bank_hit;

    assign bank_hit = req_i && (bank_idx == L2_BANK_SEL_W'(b));

    always_ff @(posedge s_soc_clk) begin
      if (bank_hit) begin
        if (we_i) begin
          for (int i = 0; i < STRB_W; i++) begin
            if (be_i[i]) begin
              mem[row_idx][8*i +: 8] <= wdata_i[8*i +: 8];
            end
          end
        end else begin
          rdata_q <= mem[row_idx];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  // remember which bank answers next cycle
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      bank_sel_q <= '0;
    end else if (req_i && !we_i) begin
      bank_sel_q <= bank_idx;
    end
  end

  assign rdata_o = bank_rdata[bank_sel_q];

endmodule

// ==== hw/boot_rom.sv ====
// ************************************************************************
// boot rom with synchronous read
// ************************************************************************

`timescale 1ns/1ns

module boot_rom import soc_pkg::*; (
  input  logic  s_soc_clk,
  input  logic  req_i,
  input  addr_t addr_i,
  output data_t rdata_o
);

  data_t rom [ROM_WORDS];
  data_t rdata_q;

  // image is one hex word per line
  initial begin
    $readmemh(ROM_FILE, rom);
  end

  always_ff @(posedge s_soc_clk) begin
    if (req_i) begin
      rdata_q <= rom[addr_i[2 +: ROM_AW]];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/apb_mem_bridge.sv ====
// ************************************************************************
// APB slave to single-cycle memory request bridge
// grant is tied to request, response strobe registered one cycle later
// ************************************************************************

`timescale 1ns/1ns

module apb_mem_bridge import soc_pkg::*; (
  input  logic  s_soc_clk,
  input  logic  s_soc_rstn,

  // apb slave side
  input  addr_t paddr_i,
  input  data_t pwdata_i,
  input  strb_t pstrb_i,
  input  logic  pwrite_i,
  input  logic  psel_i,
  input  logic  penable_i,
  output data_t prdata_o,
  output logic  pready_o,
  output logic  pslverr_o,

  // memory request side
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  output strb_t mem_be_o,
  input  data_t mem_rdata_i,
  input  logic  mem_err_i
);

  logic req_done_q;
  logic rvalid_q;

  // one request per transfer, issued in the first access cycle
  assign mem_req_o   = psel_i & penable_i & ~req_done_q;
  assign mem_we_o    = pwrite_i;
  assign mem_addr_o  = paddr_i;
  assign mem_wdata_o = pwdata_i;
  // reads fetch the full word
  assign mem_be_o    = pwrite_i ? pstrb_i : '1;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      req_done_q <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      // grant equals request, so r_valid follows it by one cycle
      rvalid_q <= mem_req_o;
      if (mem_req_o) begin
        req_done_q <= 1'b1;
      end else if (rvalid_q || !psel_i) begin
        req_done_q <= 1'b0;
      end
    end
  end

  // response strobe closes the transfer
  assign pready_o  = rvalid_q;
  assign prdata_o  = rvalid_q ? mem_rdata_i : '0;
  assign pslverr_o = rvalid_q & mem_err_i;

endmodule

// ==== hw/soc_mem_xbar.sv ====
// ************************************************************************
// address decoder and response mux for the inner memory bus
// targets are boot rom, interleaved L2 and the event counter register
// ************************************************************************

`timescale 1ns/1ns

module soc_mem_xbar import soc_pkg::*; (
  input  logic                 s_soc_clk,
  input  logic                 s_soc_rstn,

  input  logic                 mem_req_i,
  input  logic                 mem_we_i,
  input  addr_t                mem_addr_i,
  input  data_t                mem_wdata_i,
  input  strb_t                mem_be_i,
  output data_t                mem_rdata_o,
  output logic                 mem_err_o,

  // event counter register port
  output logic                 evt_clr_o,
  input  logic [EVT_CNT_W-1:0] evt_count_i
);

  tgt_e  tgt;
  tgt_e  tgt_q;
  logic  err;
  logic  err_q;
  logic  rom_req;
  logic  l2_req;
  data_t rom_rdata;
  data_t l2_rdata;

  // ************************************************************************
  // address decode
  // ************************************************************************
  always_comb begin
    if (mem_addr_i >= ROM_BASE && mem_addr_i < ROM_BASE + ROM_SPAN) begin
      tgt = TGT_ROM;
    end else if (mem_addr_i >= L2_BASE && mem_addr_i < L2_BASE + L2_SPAN) begin
      tgt = TGT_L2;
    end else if (mem_addr_i[ADDR_W-1:2] == EVT_BASE[ADDR_W-1:2]) begin
      tgt = TGT_EVT;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // unmapped access or rom write
  assign err = (tgt == TGT_NONE) || (tgt == TGT_ROM && mem_we_i);

  // rom writes never reach the array
  assign rom_req   = mem_req_i && tgt == TGT_ROM && !mem_we_i;
  assign l2_req    = mem_req_i && tgt == TGT_L2;
  assign evt_clr_o = mem_req_i && tgt == TGT_EVT && mem_we_i;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      tgt_q <= TGT_NONE;
      err_q <= 1'b0;
    end else if (mem_req_i) begin
      tgt_q <= tgt;
      err_q <= err;
    end
  end

  l2_ram_multi_bank l2_ram_i (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .req_i      (l2_req),
    .we_i       (mem_we_i),
    .addr_i     (mem_addr_i),
    .wdata_i    (mem_wdata_i),
    .be_i       (mem_be_i),
    .rdata_o    (l2_rdata)
  );

  boot_rom boot_rom_i (
    .s_soc_clk (s_soc_clk),
    .req_i     (rom_req),
    .addr_i    (mem_addr_i),
    .rdata_o   (rom_rdata)
  );

  // response mux in the r_valid cycle, errors read as zero
  always_comb begin
    mem_rdata_o = '0;
    if (!err_q) begin
      case (tgt_q)
        TGT_ROM: mem_rdata_o = rom_rdata;
        TGT_L2:  mem_rdata_o = l2_rdata;
        TGT_EVT: mem_rdata_o = {{(DATA_W-EVT_CNT_W){1'b0}}, evt_count_i};
        default: mem_rdata_o = '0;
      endcase
    end
  end

  assign mem_err_o = err_q;

endmodule

// ==== hw/pf_evt_receiver.sv ====
// ************************************************************************
// prefetch event receiver
// level handshake synchronizer plus saturating event counter
// ************************************************************************

`timescale 1ns/1ns

module pf_evt_receiver import soc_pkg::*; (
  input  logic                 s_soc_clk,
  input  logic                 s_soc_rstn,
  input  logic                 pf_evt_valid_i,
  output logic                 pf_evt_ack_o,
  input  logic                 evt_clr_i,
  output logic [EVT_CNT_W-1:0] evt_count_o
);

  logic                 sync1_q;
  logic                 sync2_q;
  logic                 sync3_q;
  logic                 evt_pulse;
  logic [EVT_CNT_W-1:0] count_q;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      sync3_q <= 1'b0;
    end else begin
      sync1_q <= pf_evt_valid_i;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
    end
  end

  // synchronized level doubles as the acknowledge
  assign pf_evt_ack_o = sync2_q;
  assign evt_pulse    = sync2_q & ~sync3_q;

  // clear has priority over a coincident event
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      count_q <= '0;
    end else if (evt_clr_i) begin
      count_q <= '0;
    end else if (evt_pulse && count_q != '1) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign evt_count_o = count_q;

endmodule

// ==== hw/soc_domain.sv ====
// ************************************************************************
// top of the SoC memory slice
// debug APB bridge, memory crossbar and prefetch event receiver
// ************************************************************************

`timescale 1ns/1ns

module soc_domain import soc_pkg::*; (
  input  logic  s_soc_clk,
  input  logic  s_soc_rstn,

  // debug apb slave
  input  addr_t paddr_i,
  input  data_t pwdata_i,
  input  strb_t pstrb_i,
  input  logic  pwrite_i,
  input  logic  psel_i,
  input  logic  penable_i,
  output data_t prdata_o,
  output logic  pready_o,
  output logic  pslverr_o,

  // prefetch event handshake
  input  logic  pf_evt_valid_i,
  output logic  pf_evt_ack_o
);

  logic                 mem_req;
  logic                 mem_we;
  addr_t                mem_addr;
  data_t                mem_wdata;
  strb_t                mem_be;
  data_t                mem_rdata;
  logic                 mem_err;
  logic                 evt_clr;
  logic [EVT_CNT_W-1:0] evt_count;

  apb_mem_bridge apb_mem_bridge_i (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .pstrb_i     (pstrb_i),
    .pwrite_i    (pwrite_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_be_o    (mem_be),
    .mem_rdata_i (mem_rdata),
    .mem_err_i   (mem_err)
  );

  soc_mem_xbar soc_mem_xbar_i (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_be_i    (mem_be),
    .mem_rdata_o (mem_rdata),
    .mem_err_o   (mem_err),
    .evt_clr_o   (evt_clr),
    .evt_count_i (evt_count)
  );

  pf_evt_receiver pf_evt_receiver_i (
    .s_soc_clk      (s_soc_clk),
    .s_soc_rstn     (s_soc_rstn),
    .pf_evt_valid_i (pf_evt_valid_i),
    .pf_evt_ack_o   (pf_evt_ack_o),
    .evt_clr_i      (evt_clr),
    .evt_count_o    (evt_count)
  );

endmodule

// ==== tests/soc_domain_properties.sv ====
// ************************************************************************
// APB bridge timing assertions, bound into apb_mem_bridge
// ************************************************************************

`timescale 1ns/1ns

module soc_domain_properties (
  input logic s_soc_clk,
  input logic s_soc_rstn,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i
);

  // response only inside the access phase
  a_pready_in_access: assert property (
    @(posedge s_soc_clk) disable iff (!s_soc_rstn)
    pready_i |-> (psel_i && penable_i)
  ) else $error("pready raised outside an APB access phase");

  // strobe follows the first access cycle by exactly one cycle
  a_rsp_after_req: assert property (
    @(posedge s_soc_clk) disable iff (!s_soc_rstn)
    (psel_i && penable_i && $past(psel_i && !penable_i)) |=> pready_i
  ) else $error("no response strobe in the second access cycle");

  // no strobe in any later access cycle
  a_rsp_needs_req: assert property (
    @(posedge s_soc_clk) disable iff (!s_soc_rstn)
    pready_i |-> $past(psel_i && !penable_i, 2)
  ) else $error("response strobe not two cycles after the setup phase");

  // error flag only in the closing access cycle
  a_err_with_ready: assert property (
    @(posedge s_soc_clk) disable iff (!s_soc_rstn)
    pslverr_i |-> (psel_i && penable_i && $past(psel_i && penable_i))
  ) else $error("pslverr raised outside the closing access cycle");

endmodule

bind apb_mem_bridge soc_domain_properties bridge_props_i (
  .s_soc_clk  (s_soc_clk),
  .s_soc_rstn (s_soc_rstn),
  .psel_i     (psel_i),
  .penable_i  (penable_i),
  .pready_i   (pready_o),
  .pslverr_i  (pslverr_o)
);

// ==== tests/tb_soc_domain.sv ====
// ************************************************************************
// testbench for the SoC memory slice
// APB driver tasks, L2 and ROM reference, event handshake, timeout
// ************************************************************************

`timescale 1ns/1ns

module tb_soc_domain import soc_pkg::*; #(
  parameter int SEED = 16368
);

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RESET_CYCLES   = 4;
  localparam int MAX_WAIT       = 8;
  localparam int NUM_RAND       = 32;
  localparam int L2_WORDS       = NB_L2_BANKS * L2_BANK_WORDS;

  logic  s_soc_clk;
  logic  s_soc_rstn;
  addr_t paddr_i;
  data_t pwdata_i;
  strb_t pstrb_i;
  logic  pwrite_i;
  logic  psel_i;
  logic  penable_i;
  data_t prdata_o;
  logic  pready_o;
  logic  pslverr_o;
  logic  pf_evt_valid_i;
  logic  pf_evt_ack_o;

  data_t l2_ref [L2_WORDS];
  int    seed;
  int    pass_count  = 0;
  int    fail_count  = 0;
  int    test_fails  = 0;
  int    cycle_count = 0;
  int    acc_cycles  = 0;

  soc_domain uut (.*);

  initial s_soc_clk = 1'b0;
  always #2 s_soc_clk = ~s_soc_clk;

  // ************************************************************************
  // reference model and checks
  // ************************************************************************
  function automatic data_t rom_word(input int idx);
    return 32'hB007_0000 + data_t'(idx);
  endfunction

  function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                        input strb_t strb);
    data_t res;
    res = old_val;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic end_test(input string name);
    if (fail_count == test_fails) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, fail_count - test_fails);
    end
    test_fails = fail_count;
  endtask

  // ************************************************************************
  // APB driver, setup then access until pready
  // ************************************************************************
  task automatic run_transfer(input addr_t addr, input data_t wdata, input strb_t strb,
                              input logic write, output data_t rdata, output logic err);
    int waited;
    @(negedge s_soc_clk);
    paddr_i   = addr;
    pwdata_i  = wdata;
    pstrb_i   = strb;
    pwrite_i  = write;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge s_soc_clk);
    penable_i = 1'b1;
    @(negedge s_soc_clk);
    waited = 1;
    while (!pready_o && waited < MAX_WAIT) begin
      @(negedge s_soc_clk);
      waited++;
    end
    if (!pready_o) begin
      $display("bridge gave no pready within %0d access cycles at t=%0t", MAX_WAIT, $time);
      fail_count++;
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge s_soc_clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input addr_t addr, input data_t wdata, input strb_t strb,
                           output logic err);
    data_t unused_rdata;
    run_transfer(addr, wdata, strb, 1'b1, unused_rdata, err);
  endtask

  task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
    run_transfer(addr, '0, '1, 1'b0, rdata, err);
  endtask

  // level handshake, ack expected 2 edges after each change of valid
  task automatic send_event();
    int edges;
    @(negedge s_soc_clk);
    pf_evt_valid_i = 1'b1;
    edges = 0;
    while (!pf_evt_ack_o && edges < MAX_WAIT) begin
      @(negedge s_soc_clk);
      edges++;
    end
    check_value("pf_evt_ack_o rise latency", data_t'(edges), 32'd2);
    pf_evt_valid_i = 1'b0;
    edges = 0;
    while (pf_evt_ack_o && edges < MAX_WAIT) begin
      @(negedge s_soc_clk);
      edges++;
    end
    check_value("pf_evt_ack_o fall latency", data_t'(edges), 32'd2);
  endtask

  // pready must close each transfer in its second access cycle
  always @(posedge s_soc_clk) begin
    if (s_soc_rstn && psel_i && penable_i) begin
      acc_cycles = acc_cycles + 1;
      if (pready_o || acc_cycles == 2) begin
        check_value("pready_o access cycle", pready_o ? data_t'(acc_cycles) : '0, 32'd2);
        acc_cycles = 0;
      end
    end else begin
      acc_cycles = 0;
    end
  end

  always @(posedge s_soc_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ************************************************************************
  // test sequence
  // ************************************************************************
  initial begin
    addr_t addr;
    data_t wdata;
    data_t rd_data;
    strb_t strb;
    logic  rd_err;
    int    idx;
    int    n_evt;
    seed           = SEED;
    s_soc_rstn     = 1'b0;
    paddr_i        = '0;
    pwdata_i       = '0;
    pstrb_i        = '0;
    pwrite_i       = 1'b0;
    psel_i         = 1'b0;
    penable_i      = 1'b0;
    pf_evt_valid_i = 1'b0;
    repeat (RESET_CYCLES) @(negedge s_soc_clk);
    s_soc_rstn = 1'b1;

    check_value("pready_o", data_t'(pready_o), '0);
    check_value("pslverr_o", data_t'(pslverr_o), '0);
    check_value("pf_evt_ack_o", data_t'(pf_evt_ack_o), '0);
    apb_read(EVT_BASE, rd_data, rd_err);
    check_value("prdata_o evt count", rd_data, '0);
    check_value("pslverr_o", data_t'(rd_err), '0);
    end_test("reset state");

    // full word first so no byte stays undefined
    for (int k = 0; k < NUM_RAND; k++) begin
      idx   = int'($unsigned($random(seed)) % L2_WORDS);
      addr  = L2_BASE + addr_t'(idx * 4);
      wdata = $random(seed);
      apb_write(addr, wdata, 4'hF, rd_err);
      check_value("pslverr_o l2 write", data_t'(rd_err), '0);
      l2_ref[idx] = wdata;
      wdata = $random(seed);
      strb  = strb_t'($random(seed));
      apb_write(addr, wdata, strb, rd_err);
      l2_ref[idx] = merge_bytes(l2_ref[idx], wdata, strb);
      apb_read(addr, rd_data, rd_err);
      check_value("prdata_o l2", rd_data, l2_ref[idx]);
      check_value("pslverr_o l2 read", data_t'(rd_err), '0);
    end
    end_test("l2 byte enables");

    for (int i = 0; i < L2_WORDS; i++) begin
      addr = L2_BASE + addr_t'(i * 4);
      apb_write(addr, addr ^ 32'hA5C3_0F96, 4'hF, rd_err);
      l2_ref[i] = addr ^ 32'hA5C3_0F96;
    end
    for (int i = L2_WORDS - 1; i >= 0; i--) begin
      apb_read(L2_BASE + addr_t'(i * 4), rd_data, rd_err);
      check_value("prdata_o l2 fill", rd_data, l2_ref[i]);
    end
    end_test("bank interleaving");

    for (int i = 0; i < ROM_WORDS; i++) begin
      apb_read(ROM_BASE + addr_t'(i * 4), rd_data, rd_err);
      check_value("prdata_o rom", rd_data, rom_word(i));
      check_value("pslverr_o rom read", data_t'(rd_err), '0);
    end
    apb_write(ROM_BASE + 32'h0C, 32'hDEAD_BEEF, 4'hF, rd_err);
    check_value("pslverr_o rom write", data_t'(rd_err), 32'd1);
    apb_read(ROM_BASE + 32'h0C, rd_data, rd_err);
    check_value("prdata_o rom reread", rd_data, rom_word(3));
    end_test("boot rom");

    apb_read(32'h3000_0000, rd_data, rd_err);
    check_value("prdata_o unmapped", rd_data, '0);
    check_value("pslverr_o unmapped read", data_t'(rd_err), 32'd1);
    apb_write(32'h3000_0000, 32'h1234_5678, 4'hF, rd_err);
    check_value("pslverr_o unmapped write", data_t'(rd_err), 32'd1);
    apb_read(L2_BASE + L2_SPAN, rd_data, rd_err);
    check_value("prdata_o past l2", rd_data, '0);
    check_value("pslverr_o past l2", data_t'(rd_err), 32'd1);
    end_test("unmapped address");

    n_evt = 3 + int'($unsigned($random(seed)) % 18);
    repeat (n_evt) send_event();
    apb_read(EVT_BASE, rd_data, rd_err);
    check_value("prdata_o evt count", rd_data, data_t'(n_evt));
    apb_write(EVT_BASE, '0, 4'hF, rd_err);
    check_value("pslverr_o evt clear", data_t'(rd_err), '0);
    apb_read(EVT_BASE, rd_data, rd_err);
    check_value("prdata_o evt cleared", rd_data, '0);
    end_test("prefetch events");

    $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hw/soc_pkg.sv
hw/l2_ram_multi_bank.sv
hw/boot_rom.sv
hw/apb_mem_bridge.sv
hw/soc_mem_xbar.sv
hw/pf_evt_receiver.sv
hw/soc_domain.sv
tests/soc_domain_properties.sv
tests/tb_soc_domain.sv

// ==== Makefile ====
# Verilator flow for the SoC memory slice: lint, simulate, clean

VERILATOR ?= verilator
TOP       ?= tb_soc_domain
RTL_TOP   ?= soc_domain
FILELIST  ?= all.f
LOG       ?= sim.log
SEED      ?= 16368
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

# RTL sources only, taken from the file list
RTL_SRCS := $(shell grep '^hw/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/boot_rom.hex ====
// one 32-bit word per line, word index 0 first
B0070000
B0070001
B0070002
B0070003
B0070004
B0070005
B0070006
B0070007
B0070008
B0070009
B007000A
B007000B
B007000C
B007000D
B007000E
B007000F
